// File: logic/gb_video_pkg.sv
`default_nettype none

package gb_video_pkg;

    // ====================
    // Clock enables
    // ====================

    // 16 system clocks per normal-speed CPU cycle
    localparam int unsigned CE_DIV_BITS = 4;

    // Opposite phase sits half a CPU cycle after the main enable
    localparam logic [CE_DIV_BITS-1:0] CE_N_PHASE = 4'd8;

    // ====================
    // Pixel widths
    // ====================

    localparam int unsigned LCD_CH_BITS  = 5;
    localparam int unsigned VGA_CH_BITS  = 8;
    localparam int unsigned NUM_CHANNELS = 3;

    // Monochrome palette, shade 0 is the lightest
    localparam logic [VGA_CH_BITS-1:0] GRAY_L0 = 8'hFF;
    localparam logic [VGA_CH_BITS-1:0] GRAY_L1 = 8'hAA;
    localparam logic [VGA_CH_BITS-1:0] GRAY_L2 = 8'h55;
    localparam logic [VGA_CH_BITS-1:0] GRAY_L3 = 8'h00;

    // ====================
    // Types
    // ====================

    // PPU mode as reported on the LCD port
    typedef enum logic [1:0] {
        MODE_HBLANK   = 2'd0,
        MODE_VBLANK   = 2'd1,
        MODE_OAM_SCAN = 2'd2,
        MODE_TRANSFER = 2'd3
    } lcd_mode_e;

    // Raw LCD port, rgb555 holds red in the top five bits
    typedef struct packed {
        logic                                clkena;
        logic [NUM_CHANNELS*LCD_CH_BITS-1:0] rgb555;
        logic [1:0]                          shade;
        lcd_mode_e                           mode;
        logic                                vsync;
    } lcd_pixel_t;

    // What one channel expander needs
    typedef struct packed {
        logic [LCD_CH_BITS-1:0] level;
        logic [1:0]             shade;
        logic                   is_gbc;
    } chan_in_t;

    typedef struct packed {
        lcd_mode_e mode;
        logic      vsync;
    } frame_flags_t;

    // Sync bits are active low for hs and vs, active high for blanks
    typedef struct packed {
        logic [VGA_CH_BITS-1:0] r;
        logic [VGA_CH_BITS-1:0] g;
        logic [VGA_CH_BITS-1:0] b;
        logic                   hs;
        logic                   vs;
        logic                   hb;
        logic                   vb;
    } vga_out_t;

endpackage

`default_nettype wire

// File: logic/clk_enable_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clk_enable_gen (
    input  logic i_clk_sys,
    input  logic i_reset,
    output logic o_ce_cpu,
    output logic o_ce_cpu_n,
    output logic o_ce_cpu2x
);
    import gb_video_pkg::*;

    // ====================
    // Divider
    // ====================

    logic [CE_DIV_BITS-1:0] clk_div;
    logic [CE_DIV_BITS-1:0] clk_div_next;

    // Enables decode the value the divider moves to on this edge,
    // so each pulse lines up with the divider wrap
    assign clk_div_next = clk_div + CE_DIV_BITS'(1);

    // ====================
    // Registered enables
    // ====================

    always_ff @(posedge i_clk_sys) begin
        if (i_reset) begin
            clk_div    <= '0;
            o_ce_cpu   <= 1'b0;
            o_ce_cpu_n <= 1'b0;
            o_ce_cpu2x <= 1'b0;
        end else begin
            clk_div    <= clk_div_next;
            // Normal speed fires once per divider wrap
            o_ce_cpu   <= (clk_div_next == '0);
            // Same rate half a period later
            o_ce_cpu_n <= (clk_div_next == CE_N_PHASE);
            // Double speed ignores the divider MSB
            o_ce_cpu2x <= (clk_div_next[CE_DIV_BITS-2:0] == '0);
        end
    end

    // ====================
    // Assertions
    // ====================

    // Double-speed enable also fired half a CPU cycle before each normal edge
    a_ce_in_2x: assert property (@(posedge i_clk_sys) disable iff (i_reset)
        o_ce_cpu |-> $past(o_ce_cpu2x, CE_N_PHASE));

    // Opposite phase follows each normal-speed edge by half a CPU cycle
    a_ce_phases: assert property (@(posedge i_clk_sys) disable iff (i_reset)
        $past(o_ce_cpu, CE_N_PHASE) |-> o_ce_cpu_n);

endmodule

`default_nettype wire

// File: logic/pixel_latch.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_latch (
    input  logic                                                    i_clk_sys,
    input  logic                                                    i_reset,
    input  gb_video_pkg::lcd_pixel_t                                i_lcd,
    input  logic                                                    i_is_gbc,
    output gb_video_pkg::chan_in_t [gb_video_pkg::NUM_CHANNELS-1:0] o_chan,
    output gb_video_pkg::frame_flags_t                              o_flags
);
    import gb_video_pkg::*;

    // Per-channel slices of the RGB555 word, index 0 is red
    logic [NUM_CHANNELS-1:0][LCD_CH_BITS-1:0] lcd_level;

    // ====================
    // Channel split
    // ====================

    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            // Red sits in the top field, blue in the bottom one
            lcd_level[i] = i_lcd.rgb555[(NUM_CHANNELS-1-i)*LCD_CH_BITS +: LCD_CH_BITS];
        end
    end

    // ====================
    // Capture
    // ====================

    always_ff @(posedge i_clk_sys) begin
        if (i_reset) begin
            // Shade 0 in gray mode, so the screen starts white
            o_chan        <= '0;
            o_flags.mode  <= MODE_HBLANK;
            o_flags.vsync <= 1'b0;
        end else begin
            // Pixel only moves on the LCD pixel clock
            if (i_lcd.clkena) begin
                for (int i = 0; i < NUM_CHANNELS; i++) begin
                    o_chan[i].level  <= lcd_level[i];
                    // Shade and game type are common to all channels
                    o_chan[i].shade  <= i_lcd.shade;
                    o_chan[i].is_gbc <= i_is_gbc;
                end
            end
            // Timing flags follow the PPU every cycle
            o_flags.mode  <= i_lcd.mode;
            o_flags.vsync <= i_lcd.vsync;
        end
    end

endmodule

`default_nettype wire

// File: logic/channel_expand.sv
`timescale 1ns/100ps
`default_nettype none

module channel_expand (
    input  logic                                 i_clk_sys,
    input  logic                                 i_reset,
    input  gb_video_pkg::chan_in_t               i_chan,
    output logic [gb_video_pkg::VGA_CH_BITS-1:0] o_level
);
    import gb_video_pkg::*;

    logic [VGA_CH_BITS-1:0] color_level;
    logic [VGA_CH_BITS-1:0] gray_level;
    logic [VGA_CH_BITS-1:0] level_next;

    // ====================
    // Colour path
    // ====================

    // Top bits repeated in the low bits, 5'h1F maps to 8'hFF
    assign color_level = {i_chan.level,
                          i_chan.level[LCD_CH_BITS-1 -: VGA_CH_BITS-LCD_CH_BITS]};

    // ====================
    // Gray path
    // ====================

    always_comb begin
        case (i_chan.shade)
            2'd0:    gray_level = GRAY_L0;
            2'd1:    gray_level = GRAY_L1;
            2'd2:    gray_level = GRAY_L2;
            default: gray_level = GRAY_L3;
        endcase
    end

    // Game type picks the path
    assign level_next = i_chan.is_gbc ? color_level : gray_level;

    // Output register, one cycle behind the latch
    always_ff @(posedge i_clk_sys) begin
        if (i_reset) begin
            o_level <= GRAY_L0;
        end else begin
            o_level <= level_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/sync_gen.sv
`timescale 1ns/100ps
`default_nettype none

module sync_gen (
    input  logic                                 i_clk_sys,
    input  logic                                 i_reset,
    input  gb_video_pkg::frame_flags_t           i_flags,
    input  logic [gb_video_pkg::NUM_CHANNELS-1:0][gb_video_pkg::VGA_CH_BITS-1:0] i_level,
    output gb_video_pkg::vga_out_t               o_vga
);
    import gb_video_pkg::*;

    logic in_hblank;
    logic in_vblank;
    logic was_hblank;
    logic hblank_entry;

    // Registered sync bits, aligned with the expander outputs
    logic hs_q;
    logic vs_q;
    logic hb_q;
    logic vb_q;

    // ====================
    // Mode decode
    // ====================

    assign in_hblank    = (i_flags.mode == MODE_HBLANK);
    assign in_vblank    = (i_flags.mode == MODE_VBLANK);
    // First latched HBlank after any other mode
    assign hblank_entry = in_hblank && !was_hblank;

    always_ff @(posedge i_clk_sys) begin
        if (i_reset) begin
            // Latch resets into HBlank, so no entry is seen right away
            was_hblank <= 1'b1;
            hs_q       <= 1'b1;
            vs_q       <= 1'b1;
            hb_q       <= 1'b1;
            vb_q       <= 1'b0;
        end else begin
            was_hblank <= in_hblank;
            // One-cycle low pulse on HBlank entry
            hs_q       <= !hblank_entry;
            vs_q       <= !i_flags.vsync;
            hb_q       <= in_hblank;
            vb_q       <= in_vblank;
        end
    end

    // ====================
    // Output packing
    // ====================

    always_comb begin
        o_vga.r  = i_level[0];
        o_vga.g  = i_level[1];
        o_vga.b  = i_level[2];
        o_vga.hs = hs_q;
        o_vga.vs = vs_q;
        o_vga.hb = hb_q;
        o_vga.vb = vb_q;
    end

    // HSync low never lasts past one cycle
    a_hs_single: assert property (@(posedge i_clk_sys) disable iff (i_reset)
        !o_vga.hs |=> o_vga.hs);

endmodule

`default_nettype wire

// File: logic/gb_video_out.sv
`timescale 1ns/100ps
`default_nettype none

module gb_video_out (
    input  logic                     i_clk_sys,
    input  logic                     i_reset,
    input  gb_video_pkg::lcd_pixel_t i_lcd,
    input  logic                     i_is_gbc,
    output gb_video_pkg::vga_out_t   o_vga,
    output logic                     o_ce_cpu,
    output logic                     o_ce_cpu_n,
    output logic                     o_ce_cpu2x
);
    import gb_video_pkg::*;

    // Latched pixel, one entry per colour channel
    chan_in_t [NUM_CHANNELS-1:0]              chan;
    frame_flags_t                             flags;
    // Expanded 8-bit levels, red first
    logic [NUM_CHANNELS-1:0][VGA_CH_BITS-1:0] level;

    // ====================
    // CPU clock enables
    // ====================

    clk_enable_gen u_clk_enable_gen (
        .i_clk_sys  (i_clk_sys),
        .i_reset    (i_reset),
        .o_ce_cpu   (o_ce_cpu),
        .o_ce_cpu_n (o_ce_cpu_n),
        .o_ce_cpu2x (o_ce_cpu2x)
    );

    // ====================
    // Pixel path
    // ====================

    pixel_latch u_pixel_latch (
        .i_clk_sys (i_clk_sys),
        .i_reset   (i_reset),
        .i_lcd     (i_lcd),
        .i_is_gbc  (i_is_gbc),
        .o_chan    (chan),
        .o_flags   (flags)
    );

    // Same expander for red, green and blue
    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
        channel_expand u_channel_expand (
            .i_clk_sys (i_clk_sys),
            .i_reset   (i_reset),
            .i_chan    (chan[i]),
            .o_level   (level[i])
        );
    end

    // Sync flags catch up with the expanders here
    sync_gen u_sync_gen (
        .i_clk_sys (i_clk_sys),
        .i_reset   (i_reset),
        .i_flags   (flags),
        .i_level   (level),
        .o_vga     (o_vga)
    );

endmodule

`default_nettype wire

// File: bench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ====================
// Counters
// ====================

int err_total    = 0;
int err_test     = 0;
int tests_run    = 0;
int tests_failed = 0;

task automatic flag_mismatch(input string name, input logic [23:0] exp_val,
                             input logic [23:0] got_val);
    $display("Fail at %0t: %s expected %h, got %h", $time, name, exp_val, got_val);
    err_total++;
    err_test++;
endtask

// ====================
// Checks
// ====================

// CPU enables against the edge count since reset
a_ce_cpu: assert property (@(posedge clk_sys) disable iff (reset) ce_cpu == exp_ce_cpu)
    else flag_mismatch("o_ce_cpu", {23'd0, $sampled(exp_ce_cpu)}, {23'd0, $sampled(ce_cpu)});
a_ce_cpu_n: assert property (@(posedge clk_sys) disable iff (reset) ce_cpu_n == exp_ce_cpu_n)
    else flag_mismatch("o_ce_cpu_n", {23'd0, $sampled(exp_ce_cpu_n)},
                       {23'd0, $sampled(ce_cpu_n)});
a_ce_cpu2x: assert property (@(posedge clk_sys) disable iff (reset) ce_cpu2x == exp_ce_cpu2x)
    else flag_mismatch("o_ce_cpu2x", {23'd0, $sampled(exp_ce_cpu2x)},
                       {23'd0, $sampled(ce_cpu2x)});

// Gray, colour and hold all land on the packed r, g, b
a_rgb: assert property (@(posedge clk_sys) disable iff (reset) {vga.r, vga.g, vga.b} == exp_rgb)
    else flag_mismatch("o_vga.rgb", $sampled(exp_rgb), $sampled({vga.r, vga.g, vga.b}));

a_hs: assert property (@(posedge clk_sys) disable iff (reset) vga.hs == exp_hs)
    else flag_mismatch("o_vga.hs", {23'd0, $sampled(exp_hs)}, {23'd0, $sampled(vga.hs)});
a_hb: assert property (@(posedge clk_sys) disable iff (reset)
    vga.hb == (mode_d2 == MODE_HBLANK))
    else flag_mismatch("o_vga.hb", {23'd0, $sampled(mode_d2 == MODE_HBLANK)},
                       {23'd0, $sampled(vga.hb)});
a_vb: assert property (@(posedge clk_sys) disable iff (reset)
    vga.vb == (mode_d2 == MODE_VBLANK))
    else flag_mismatch("o_vga.vb", {23'd0, $sampled(mode_d2 == MODE_VBLANK)},
                       {23'd0, $sampled(vga.vb)});
// VSync output is active low
a_vs: assert property (@(posedge clk_sys) disable iff (reset) vga.vs == !vsync_d2)
    else flag_mismatch("o_vga.vs", {23'd0, $sampled(!vsync_d2)}, {23'd0, $sampled(vga.vs)});

`endif

// File: bench/tb_gb_video_out.sv
`timescale 1ns/100ps
`default_nettype none

module tb_gb_video_out;
    import gb_video_pkg::*;

    // ====================
    // Run length
    // ====================

    // Driven cycles per test, each test then drains the pipeline
    localparam int CE_CYCLES     = 48;
    localparam int GRAY_CYCLES   = 4;
    localparam int COLOUR_CYCLES = 32;
    localparam int HOLD_CYCLES   = 13;
    localparam int HSYNC_CYCLES  = 8;
    localparam int FLAG_CYCLES   = 40;
    localparam int FLUSH_CYCLES  = 4;
    // Twice the test work plus reset and margin, near 600 cycles
    localparam int TIMEOUT_CYCLES = 2 * (CE_CYCLES + GRAY_CYCLES + COLOUR_CYCLES + HOLD_CYCLES
                                         + HSYNC_CYCLES + FLAG_CYCLES + 6 * FLUSH_CYCLES) + 260;

    logic        clk_sys;
    logic        reset;
    lcd_pixel_t  lcd;
    logic        is_gbc;
    vga_out_t    vga;
    logic        ce_cpu;
    logic        ce_cpu_n;
    logic        ce_cpu2x;
    logic [31:0] rng_state;
    int          cycle_count;

    // Mode walk for the HSync test
    lcd_mode_e   hs_walk [5] = '{MODE_TRANSFER, MODE_HBLANK, MODE_HBLANK,
                                 MODE_OAM_SCAN, MODE_HBLANK};

    // ====================
    // Reference model
    // ====================

    // Edges since reset release, modulo the CPU period
    logic [3:0]  ce_count;
    logic        ce_run;
    // Last pixel taken with clkena high
    logic [14:0] held_rgb;
    logic [1:0]  held_shade;
    logic        held_gbc;
    logic [23:0] exp_rgb;
    // Input history, d2 is the sample two edges back
    lcd_mode_e   mode_d1;
    lcd_mode_e   mode_d2;
    lcd_mode_e   mode_d3;
    logic        vsync_d1;
    logic        vsync_d2;
    logic        exp_ce_cpu;
    logic        exp_ce_cpu_n;
    logic        exp_ce_cpu2x;
    logic        exp_hs;

    assign exp_ce_cpu   = ce_run && (ce_count == 4'd0);
    assign exp_ce_cpu_n = ce_run && (ce_count == 4'd8);
    assign exp_ce_cpu2x = ce_run && (ce_count[2:0] == 3'd0);
    // Low only on the first HBlank sample after another mode
    assign exp_hs       = !(mode_d2 == MODE_HBLANK && mode_d3 != MODE_HBLANK);

    `include "tb_checks.svh"

    gb_video_out u_gb_video_out (
        .i_clk_sys  (clk_sys),
        .i_reset    (reset),
        .i_lcd      (lcd),
        .i_is_gbc   (is_gbc),
        .o_vga      (vga),
        .o_ce_cpu   (ce_cpu),
        .o_ce_cpu_n (ce_cpu_n),
        .o_ce_cpu2x (ce_cpu2x)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Colour repeats the top 3 bits, gray picks white to black
    function automatic logic [7:0] expand_level(input logic [4:0] level,
                                                input logic [1:0] shade, input logic gbc);
        logic [7:0] gray;
        case (shade)
            2'd0:    gray = 8'hFF;
            2'd1:    gray = 8'hAA;
            2'd2:    gray = 8'h55;
            default: gray = 8'h00;
        endcase
        return gbc ? {level, level[4:2]} : gray;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            ce_count   <= 4'd0;
            ce_run     <= 1'b0;
            held_rgb   <= '0;
            held_shade <= 2'd0;
            held_gbc   <= 1'b0;
            exp_rgb    <= 24'hFFFFFF;
            mode_d1    <= MODE_HBLANK;
            mode_d2    <= MODE_HBLANK;
            mode_d3    <= MODE_HBLANK;
            vsync_d1   <= 1'b0;
            vsync_d2   <= 1'b0;
        end else begin
            ce_count <= ce_count + 4'd1;
            ce_run   <= 1'b1;
            if (lcd.clkena) begin
                held_rgb   <= lcd.rgb555;
                held_shade <= lcd.shade;
                held_gbc   <= is_gbc;
            end
            // Red is the top field of the RGB555 word
            exp_rgb  <= {expand_level(held_rgb[14:10], held_shade, held_gbc),
                         expand_level(held_rgb[9:5], held_shade, held_gbc),
                         expand_level(held_rgb[4:0], held_shade, held_gbc)};
            mode_d1  <= lcd.mode;
            mode_d2  <= mode_d1;
            mode_d3  <= mode_d2;
            vsync_d1 <= lcd.vsync;
            vsync_d2 <= vsync_d1;
        end
    end

    // ====================
    // Stimulus helpers
    // ====================

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic random_pixel();
        rng_state  = lcg_next(rng_state);
        lcd.rgb555 = rng_state[30:16];
        lcd.shade  = rng_state[9:8];
    endtask

    task automatic finish_test(input string name);
        // Let late results of the 2-stage pipeline land in this test
        repeat (FLUSH_CYCLES) next_cycle();
        tests_run++;
        if (err_test == 0) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name, err_test);
        end
        err_test = 0;
    endtask

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    // ====================
    // Test sequence
    // ====================

    initial begin
        reset     = 1'b1;
        lcd       = '0;
        is_gbc    = 1'b0;
        rng_state = 32'h8186_0f02;
        repeat (2) @(posedge clk_sys);
        #1;
        reset = 1'b0;

        repeat (CE_CYCLES) next_cycle();
        finish_test("clock enables");

        // Monochrome game, one shade per pixel clock
        lcd.clkena = 1'b1;
        for (int s = 0; s < GRAY_CYCLES; s++) begin
            lcd.shade = 2'(s);
            next_cycle();
        end
        finish_test("gray palette");

        is_gbc = 1'b1;
        repeat (COLOUR_CYCLES) begin
            random_pixel();
            next_cycle();
        end
        finish_test("colour expansion");

        // One captured pixel, then noise while clkena is low
        random_pixel();
        next_cycle();
        lcd.clkena = 1'b0;
        repeat (HOLD_CYCLES - 1) begin
            random_pixel();
            next_cycle();
        end
        finish_test("hold");

        for (int i = 0; i < 5; i++) begin
            lcd.mode = hs_walk[i];
            next_cycle();
        end
        repeat (HSYNC_CYCLES - 5) next_cycle();
        finish_test("hsync");

        repeat (FLAG_CYCLES) begin
            rng_state = lcg_next(rng_state);
            lcd.mode  = lcd_mode_e'(rng_state[21:20]);
            lcd.vsync = rng_state[24];
            next_cycle();
        end
        finish_test("blank flags and vsync");

        $display("Summary: %0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, err_total);
        if (err_total == 0 && tests_failed == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog on the system clock
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_sys);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: gb_video_out.f
+incdir+bench
logic/gb_video_pkg.sv
logic/clk_enable_gen.sv
logic/pixel_latch.sv
logic/channel_expand.sv
logic/sync_gen.sv
logic/gb_video_out.sv
bench/tb_gb_video_out.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_gb_video_out
FILELIST  = gb_video_out.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
